/* hw/core_config_pkg.sv */
// Core sizing constants
`default_nettype none

package core_config_pkg;

    //////////////////////////////
    // Slot and datapath sizing
    //////////////////////////////

    // Reservation-station slots in the execution row
    localparam int NUM_SLOTS = 4;

    // Data word width
    localparam int XLEN = 32;

    // Program-order tag width, reorder buffer has 2**SEQ_WIDTH entries
    localparam int SEQ_WIDTH = 3;
    localparam int ROB_DEPTH = 2 ** SEQ_WIDTH;

    // In-flight counter must reach NUM_SLOTS itself
    localparam int FLIGHT_WIDTH = $clog2(NUM_SLOTS + 1);

endpackage

`default_nettype wire

/* hw/core_types_pkg.sv */
// Core packet and opcode types
`default_nettype none

package core_types_pkg;

    import core_config_pkg::*;

    //////////////////////////////
    // Plain vector types
    //////////////////////////////

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [SEQ_WIDTH-1:0] seq_t;
    typedef logic [NUM_SLOTS-1:0] slot_mask_t;

    // Opcodes, three bits
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_XOR = 3'd3,
        OP_MUL = 3'd4
    } alu_op_e;

    //////////////////////////////
    // Packets
    //////////////////////////////

    // Operation from outside, 67 bits
    typedef struct packed {
        alu_op_e op;
        word_t   a;
        word_t   b;
    } op_packet_t;

    // Operation tagged for a slot, 70 bits
    typedef struct packed {
        op_packet_t op_pkt;
        seq_t       seq;
    } issue_packet_t;

    // Finished operation, 38 bits
    typedef struct packed {
        seq_t    seq;
        alu_op_e op;
        word_t   value;
    } result_packet_t;

    //////////////////////////////
    // State machines
    //////////////////////////////

    typedef enum logic [1:0] {
        SLOT_IDLE,
        SLOT_BUSY,
        SLOT_DONE
    } slot_state_e;

    typedef enum logic [1:0] {
        COMMIT_IDLE,
        COMMIT_REQ,
        COMMIT_WAIT_LOW
    } commit_state_e;

endpackage

`default_nettype wire

/* hw/dispatch_unit.sv */
// Operation dispatcher
`timescale 1ns/1ps
`default_nettype none

module dispatch_unit (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          in_req,
    input  core_types_pkg::op_packet_t    in_op,
    output logic                          in_ack,
    input  core_types_pkg::slot_mask_t    slot_busy,
    input  logic                          retire,
    output core_types_pkg::slot_mask_t    issue_valid,
    output core_types_pkg::issue_packet_t issue_packet
);

    import core_config_pkg::*;
    import core_types_pkg::*;

    logic                    accept;
    logic                    room;
    slot_mask_t              free_pick;
    logic [FLIGHT_WIDTH-1:0] in_flight;
    seq_t                    next_seq;

    // Lowest-numbered free slot, one-hot
    always_comb begin
        free_pick = '0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (!slot_busy[i]) begin
                free_pick = '0;
                free_pick[i] = 1'b1;
            end
        end
    end

    // Room left under the in-flight limit
    assign room = in_flight < FLIGHT_WIDTH'(NUM_SLOTS);

    // New request, ack still low, room and a slot
    assign accept = in_req && !in_ack && room && (|free_pick);

    assign issue_valid  = accept ? free_pick : '0;
    assign issue_packet = '{op_pkt: in_op, seq: next_seq};

    //////////////////////////////
    // Handshake and counters
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            in_ack    <= 1'b0;
            in_flight <= '0;
            next_seq  <= '0;
        end else begin
            // Ack rises on accept, falls once req is gone
            if (accept) begin
                in_ack <= 1'b1;
            end else if (!in_req) begin
                in_ack <= 1'b0;
            end
            if (accept) begin
                next_seq <= next_seq + seq_t'(1);
            end
            // Dispatch and retire may coincide
            case ({accept, retire})
                2'b10:   in_flight <= in_flight + FLIGHT_WIDTH'(1);
                2'b01:   in_flight <= in_flight - FLIGHT_WIDTH'(1);
                default: in_flight <= in_flight;
            endcase
        end
    end

    // Issue goes to at most one slot
    a_issue_onehot: assert property (@(posedge clock) disable iff (reset)
        $onehot0(issue_valid))
        else $error("issue_valid not one-hot: %h", issue_valid);

    // Picked slot takes the operation on the issue edge
    a_issue_taken: assert property (@(posedge clock) disable iff (reset)
        (issue_valid != '0) |=> ((slot_busy & $past(issue_valid)) == $past(issue_valid)))
        else $error("issued slot not busy: %h busy %h", $past(issue_valid), slot_busy);

endmodule

`default_nettype wire

/* hw/exec_slot.sv */
// Reservation-station execution slot
`timescale 1ns/1ps
`default_nettype none

module exec_slot (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           load,
    input  core_types_pkg::issue_packet_t  issue_packet,
    input  logic                           clear,
    output logic                           busy,
    output logic                           done,
    output core_types_pkg::result_packet_t result
);

    import core_types_pkg::*;

    slot_state_e state;

    // Held operation
    alu_op_e op_q;
    seq_t    seq_q;
    word_t   a_q;
    word_t   b_q;

    // Result, also the multiply accumulator
    word_t acc;
    word_t alu_value;
    logic  last_step;

    // Single-step ALU
    always_comb begin
        case (op_q)
            OP_ADD:  alu_value = a_q + b_q;
            OP_SUB:  alu_value = a_q - b_q;
            OP_AND:  alu_value = a_q & b_q;
            OP_XOR:  alu_value = a_q ^ b_q;
            default: alu_value = '0;
        endcase
    end

    // Multiplier runs out after this bit
    assign last_step = (b_q >> 1) == '0;

    //////////////////////////////
    // Slot FSM
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= SLOT_IDLE;
        end else begin
            case (state)
                SLOT_IDLE: if (load) state <= SLOT_BUSY;
                SLOT_BUSY: if (op_q != OP_MUL || last_step) state <= SLOT_DONE;
                SLOT_DONE: if (clear) state <= SLOT_IDLE;
                default:   state <= SLOT_IDLE;
            endcase
        end
    end

    // Datapath, no reset on payload
    always_ff @(posedge clock) begin
        if (load) begin
            op_q  <= issue_packet.op_pkt.op;
            a_q   <= issue_packet.op_pkt.a;
            b_q   <= issue_packet.op_pkt.b;
            seq_q <= issue_packet.seq;
            acc   <= '0;
        end else if (state == SLOT_BUSY) begin
            if (op_q == OP_MUL) begin
                // Shift-and-add, one multiplier bit per cycle
                acc <= acc + (b_q[0] ? a_q : '0);
                a_q <= a_q << 1;
                b_q <= b_q >> 1;
            end else begin
                acc <= alu_value;
            end
        end
    end

    assign busy   = state != SLOT_IDLE;
    assign done   = state == SLOT_DONE;
    assign result = '{seq: seq_q, op: op_q, value: acc};

    // Dispatcher only loads an idle slot
    a_load_idle: assert property (@(posedge clock) disable iff (reset)
        load |-> state == SLOT_IDLE)
        else $error("load in state %h", state);

endmodule

`default_nettype wire

/* hw/commit_unit.sv */
// In-order commit with reorder buffer
`timescale 1ns/1ps
`default_nettype none

module commit_unit (
    input  logic                           clock,
    input  logic                           reset,
    input  core_types_pkg::slot_mask_t     slot_done,
    input  core_types_pkg::result_packet_t slot_result [core_config_pkg::NUM_SLOTS],
    output core_types_pkg::slot_mask_t     slot_clear,
    output logic                           retire,
    output logic                           commit_req,
    output core_types_pkg::result_packet_t commit_result,
    input  logic                           commit_ack
);

    import core_config_pkg::*;
    import core_types_pkg::*;

    commit_state_e state;

    // Reorder buffer indexed by seq
    logic [ROB_DEPTH-1:0] rob_valid;
    result_packet_t       rob_data [ROB_DEPTH];
    seq_t                 head;

    // Every done slot is captured at once
    assign slot_clear = slot_done;

    assign commit_req    = state == COMMIT_REQ;
    assign commit_result = rob_data[head];
    assign retire        = commit_req && commit_ack;

    //////////////////////////////
    // Buffer control
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            rob_valid <= '0;
            head      <= '0;
        end else begin
            // Head leaves on ack
            if (retire) begin
                rob_valid[head] <= 1'b0;
                head            <= head + seq_t'(1);
            end
            for (int i = 0; i < NUM_SLOTS; i++) begin
                if (slot_done[i]) begin
                    rob_valid[slot_result[i].seq] <= 1'b1;
                end
            end
        end
    end

    // Result payload
    always_ff @(posedge clock) begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (slot_done[i]) begin
                rob_data[slot_result[i].seq] <= slot_result[i];
            end
        end
    end

    //////////////////////////////
    // Output handshake FSM
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= COMMIT_IDLE;
        end else begin
            case (state)
                // Req one cycle after head is valid
                COMMIT_IDLE:     if (rob_valid[head]) state <= COMMIT_REQ;
                COMMIT_REQ:      if (commit_ack) state <= COMMIT_WAIT_LOW;
                // Ack must fall before next result
                COMMIT_WAIT_LOW: if (!commit_ack) state <= COMMIT_IDLE;
                default:         state <= COMMIT_IDLE;
            endcase
        end
    end

    // Presented result holds until acked
    a_result_stable: assert property (@(posedge clock) disable iff (reset)
        (commit_req && !commit_ack) |=> (commit_req && $stable(commit_result)))
        else $error("commit_result changed under req: %h", commit_result);

    // Seq tags never alias a pending entry
    for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_capture_chk
        a_no_overwrite: assert property (@(posedge clock) disable iff (reset)
            slot_done[i] |-> !rob_valid[slot_result[i].seq])
            else $error("slot %0d overwrites seq %h", i, slot_result[i].seq);
    end

endmodule

`default_nettype wire

/* hw/ooo_core.sv */
// Out-of-order core top level
`timescale 1ns/1ps
`default_nettype none

module ooo_core (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           in_req,
    input  core_types_pkg::op_packet_t     in_op,
    output logic                           in_ack,
    output logic                           commit_req,
    output core_types_pkg::result_packet_t commit_result,
    input  logic                           commit_ack
);

    import core_config_pkg::*;
    import core_types_pkg::*;

    //////////////////////////////
    // Internal wires
    //////////////////////////////

    // Dispatcher to slots
    slot_mask_t    issue_valid;
    issue_packet_t issue_packet;

    // Slots to dispatcher and commit
    slot_mask_t     slot_busy;
    slot_mask_t     slot_done;
    result_packet_t slot_result [NUM_SLOTS];

    // Commit back to slots and dispatcher
    slot_mask_t slot_clear;
    logic       retire;

    dispatch_unit dispatch_unit_0 (
        .clock        (clock),
        .reset        (reset),
        .in_req       (in_req),
        .in_op        (in_op),
        .in_ack       (in_ack),
        .slot_busy    (slot_busy),
        .retire       (retire),
        .issue_valid  (issue_valid),
        .issue_packet (issue_packet)
    );

    // Row of identical slots sharing one issue bus
    for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
        exec_slot exec_slot_i (
            .clock        (clock),
            .reset        (reset),
            .load         (issue_valid[i]),
            .issue_packet (issue_packet),
            .clear        (slot_clear[i]),
            .busy         (slot_busy[i]),
            .done         (slot_done[i]),
            .result       (slot_result[i])
        );
    end

    commit_unit commit_unit_0 (
        .clock         (clock),
        .reset         (reset),
        .slot_done     (slot_done),
        .slot_result   (slot_result),
        .slot_clear    (slot_clear),
        .retire        (retire),
        .commit_req    (commit_req),
        .commit_result (commit_result),
        .commit_ack    (commit_ack)
    );

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clock,
    output logic reset
);

    // 20 ns period
    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 10;

    initial begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

    // Reset held for ten edges, released just after one
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

/* testbench/ooo_core_tb.sv */
// Out-of-order core testbench
`timescale 1ns/1ps
`default_nettype none

module ooo_core_tb;

    import core_config_pkg::*;
    import core_types_pkg::*;

    localparam int          WAIT_LIMIT  = 300;
    localparam int          HOLD_CYCLES = 20;
    localparam int          EXP_BITS    = 6;
    localparam logic [31:0] LCG_SEED    = 32'd90;

    logic clock;
    logic reset;

    // DUT ports
    logic           in_req;
    op_packet_t     in_op;
    logic           in_ack;
    logic           commit_req;
    result_packet_t commit_result;
    logic           commit_ack;

    // Expected results in dispatch order
    result_packet_t expected_mem [2**EXP_BITS];
    result_packet_t exp_head;
    int             pushed = 0;
    int             committed;
    int             outstanding;
    logic           in_ack_q;
    logic           req_seen = 1'b0;

    // Commit responder control
    logic hold_ack  = 1'b0;
    int   ack_delay = 0;

    int          check_errors = 0;
    int          timeouts     = 0;
    logic        aborted      = 1'b0;
    logic [31:0] rng_state    = LCG_SEED;

    tb_clock_gen clock_gen (
        .clock (clock),
        .reset (reset)
    );

    ooo_core uut (
        .clock         (clock),
        .reset         (reset),
        .in_req        (in_req),
        .in_op         (in_op),
        .in_ack        (in_ack),
        .commit_req    (commit_req),
        .commit_result (commit_result),
        .commit_ack    (commit_ack)
    );

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t rand_word();
        rng_state = lcg_next(rng_state);
        return rng_state;
    endfunction

    // All results wrap to 32 bits
    function automatic word_t rule_result(input alu_op_e op, input word_t a, input word_t b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_XOR:  return a ^ b;
            default: return a * b;
        endcase
    endfunction

    function void note_error(input string msg);
        check_errors++;
        $display("%s", msg);
    endfunction

    assign exp_head = expected_mem[EXP_BITS'(committed)];

    // Handshake bookkeeping, counted once per completed phase
    always_ff @(posedge clock) begin
        in_ack_q <= in_ack;
        if (reset) begin
            committed   <= 0;
            outstanding <= 0;
        end else begin
            if (commit_req && commit_ack) begin
                committed <= committed + 1;
            end
            outstanding <= outstanding + int'(in_ack && !in_ack_q)
                         - int'(commit_req && commit_ack);
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    a_idle_until_req: assert property (@(posedge clock) disable iff (reset)
        !req_seen |-> (!in_ack && !commit_req))
        else note_error($sformatf("ERROR in_ack %h commit_req %h before first in_req",
            $sampled(in_ack), $sampled(commit_req)));

    a_commit_pending: assert property (@(posedge clock) disable iff (reset)
        commit_req |-> committed < pushed)
        else note_error("Commit presented with no operation outstanding");

    // Compared against the queue head, which follows dispatch order
    a_commit_value: assert property (@(posedge clock) disable iff (reset)
        (commit_req && committed < pushed) |-> commit_result.value == exp_head.value)
        else note_error($sformatf("ERROR commit_result.value %h expected %h",
            $sampled(commit_result.value), $sampled(exp_head.value)));

    // Tag ascends modulo 8
    a_commit_seq: assert property (@(posedge clock) disable iff (reset)
        (commit_req && committed < pushed) |-> commit_result.seq == exp_head.seq)
        else note_error($sformatf("ERROR commit_result.seq %h expected %h",
            $sampled(commit_result.seq), $sampled(exp_head.seq)));

    a_commit_op: assert property (@(posedge clock) disable iff (reset)
        (commit_req && committed < pushed) |-> commit_result.op == exp_head.op)
        else note_error($sformatf("ERROR commit_result.op %h expected %h",
            $sampled(commit_result.op), $sampled(exp_head.op)));

    a_flight_limit: assert property (@(posedge clock) disable iff (reset)
        $rose(in_ack) |-> $past(outstanding) < NUM_SLOTS)
        else note_error("in_ack rose with every slot already in flight");

    // Four-phase rules on both sides
    a_in_ack_needs_req: assert property (@(posedge clock) disable iff (reset)
        $rose(in_ack) |-> $past(in_req))
        else note_error("in_ack rose without in_req");

    a_in_ack_holds: assert property (@(posedge clock) disable iff (reset)
        $fell(in_ack) |-> !$past(in_req))
        else note_error("in_ack dropped while in_req was still high");

    a_commit_req_holds: assert property (@(posedge clock) disable iff (reset)
        $fell(commit_req) |-> $past(commit_ack))
        else note_error("commit_req dropped before commit_ack");

    a_commit_stable: assert property (@(posedge clock) disable iff (reset)
        (commit_req && $past(commit_req)) |-> $stable(commit_result))
        else note_error($sformatf("ERROR commit_result changed to %h under commit_req",
            $sampled(commit_result)));

    //////////////////////////////
    // Stimulus tasks
    //////////////////////////////

    task automatic step();
        @(posedge clock);
        #1;
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        aborted = 1'b1;
        $display("Timeout waiting for %s", what);
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (reset && cycles < WAIT_LIMIT) begin
            step();
            cycles++;
        end
        if (reset) begin
            report_timeout("reset release");
        end
    endtask

    task automatic wait_in_ack(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (!aborted && in_ack !== level && cycles < WAIT_LIMIT) begin
            step();
            cycles++;
        end
        if (!aborted && in_ack !== level) begin
            report_timeout(what);
        end
    endtask

    // Every pushed result committed and the output side back at rest
    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (!aborted && (committed != pushed || commit_ack) && cycles < WAIT_LIMIT) begin
            step();
            cycles++;
        end
        if (!aborted && (committed != pushed || commit_ack)) begin
            report_timeout("all results to commit");
        end
    endtask

    task automatic raise_req(input alu_op_e op, input word_t a, input word_t b);
        result_packet_t exp;
        if (aborted) return;
        in_op    = '{op: op, a: a, b: b};
        in_req   = 1'b1;
        req_seen = 1'b1;
        exp.seq   = seq_t'(pushed);
        exp.op    = op;
        exp.value = rule_result(op, a, b);
        expected_mem[EXP_BITS'(pushed)] = exp;
        pushed++;
    endtask

    task automatic finish_handshake();
        wait_in_ack(1'b1, "in_ack high");
        in_req = 1'b0;
        wait_in_ack(1'b0, "in_ack low");
    endtask

    task automatic send_op(input alu_op_e op, input word_t a, input word_t b);
        raise_req(op, a, b);
        finish_handshake();
    endtask

    // Output side partner with a programmable ack delay
    initial begin : commit_responder
        int wait_count;
        commit_ack = 1'b0;
        wait_count = 0;
        forever begin
            step();
            if (commit_ack) begin
                if (!commit_req) commit_ack = 1'b0;
            end else if (commit_req && !hold_ack) begin
                if (wait_count >= ack_delay) begin
                    commit_ack = 1'b1;
                    wait_count = 0;
                end else begin
                    wait_count++;
                end
            end
        end
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin : stimulus
        int k;
        in_req = 1'b0;
        in_op  = '0;
        wait_reset_release();
        // Quiet window before the first request
        for (k = 0; k < 5; k++) step();

        // ALU ops on random operands
        for (k = 0; k < 16; k++) send_op(alu_op_e'(k[1:0]), rand_word(), rand_word());
        wait_drain();

        // MUL corners, slow commit side
        ack_delay = 3;
        send_op(OP_MUL, rand_word(), 32'h0000_0000);
        send_op(OP_MUL, rand_word(), 32'h8000_0001);
        send_op(OP_MUL, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
        send_op(OP_MUL, rand_word(), rand_word());
        send_op(OP_MUL, rand_word(), 32'h0000_0001);
        wait_drain();

        // Long MUL ahead of short ops
        ack_delay = 0;
        send_op(OP_MUL, rand_word(), 32'hFFFF_FFFF);
        send_op(OP_ADD, rand_word(), rand_word());
        send_op(OP_SUB, rand_word(), rand_word());
        send_op(OP_AND, rand_word(), rand_word());
        send_op(OP_XOR, rand_word(), rand_word());
        wait_drain();

        // Back-pressure with commit_ack withheld
        hold_ack = 1'b1;
        send_op(OP_ADD, rand_word(), rand_word());
        send_op(OP_MUL, rand_word(), 32'h0000_00F0);
        send_op(OP_XOR, rand_word(), rand_word());
        send_op(OP_SUB, rand_word(), rand_word());
        raise_req(OP_AND, rand_word(), rand_word());
        for (k = 0; k < HOLD_CYCLES; k++) step();
        hold_ack = 1'b0;
        finish_handshake();
        wait_drain();

        $display("Checks done: %0d ops, %0d commits, %0d check errors, %0d timeouts",
            pushed, committed, check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
hw/core_config_pkg.sv
hw/core_types_pkg.sv
hw/dispatch_unit.sv
hw/exec_slot.sv
hw/commit_unit.sv
hw/ooo_core.sv
testbench/tb_clock_gen.sv
testbench/ooo_core_tb.sv

/* Makefile */
VERILATOR  := verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
TOP        := ooo_core_tb
FILELIST   := compile.f
OBJ_DIR    := obj_dir
PASS_MSG   := sim passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Output shown, status taken from the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
